/* Bender.yml */
package:
  name: zmem

sources:
  - rtl/zmem_pkg.sv
  - rtl/zclk_phase.sv
  - rtl/zmem_pager.sv
  - rtl/zmem_word_cache.sv
  - rtl/zmem_ctrl.sv
  - rtl/dram_slot_arb.sv
  - rtl/zmem_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_zmem.sv

/* flist.f */
+incdir+tests
rtl/zmem_pkg.sv
rtl/zclk_phase.sv
rtl/zmem_pager.sv
rtl/zmem_word_cache.sv
rtl/zmem_ctrl.sv
rtl/dram_slot_arb.sv
rtl/zmem_top.sv
tests/tb_zmem.sv

/* rtl/dram_slot_arb.sv */
`timescale 1ns/1ps

module dram_slot_arb #(
	parameter int VIDEO_PERIOD    = 4,  // one video slot per period, 0 - none
	parameter int DRAM_WORDS_LOG2 = 12
) (
	input  logic             fclk,
	input  logic             rst_n,
	input  logic             c2,
	input  logic             c3,
	input  logic             cpu_req,
	input  logic             cpu_rnw,
	input  zmem_pkg::daddr_t cpu_addr,
	input  zmem_pkg::zdata_t cpu_wrdata,
	input  logic             cpu_wrbsel, // 1 - high byte
	output logic             cpu_next,
	output logic             cpu_strobe,
	output zmem_pkg::dword_t cpu_rddata
);

	localparam int SLOT_W = (VIDEO_PERIOD > 1) ? $clog2(VIDEO_PERIOD) : 1;

	zmem_pkg::dword_t           mem [2**DRAM_WORDS_LOG2];
	logic [SLOT_W-1:0]          slot_cnt; // advances once per c0..c3 slot
	logic [DRAM_WORDS_LOG2-1:0] widx;     // upper page bits wrap
	logic                       grant;
	logic                       rd_pend;  // read granted, strobe due on c2

	assign widx  = cpu_addr[DRAM_WORDS_LOG2-1:0];
	assign grant = cpu_req & cpu_next & c3;

	always_ff @(posedge fclk or negedge rst_n)
	if (!rst_n)
		slot_cnt <= '0;
	else if (c3)
	begin
		if (VIDEO_PERIOD < 2 || slot_cnt == SLOT_W'(VIDEO_PERIOD - 1))
			slot_cnt <= '0;
		else
			slot_cnt <= slot_cnt + 1'b1;
	end

	assign cpu_next = (VIDEO_PERIOD == 0) || (slot_cnt != '0); // slot 0 goes to video

	// byte write or word read at the grant
	always_ff @(posedge fclk)
	if (grant)
	begin
		if (!cpu_rnw)
		begin
			if (cpu_wrbsel)
				mem[widx][15:8] <= cpu_wrdata;
			else
				mem[widx][7:0] <= cpu_wrdata;
		end
		else
			cpu_rddata <= mem[widx];
	end

	always_ff @(posedge fclk or negedge rst_n)
	if (!rst_n)
		rd_pend <= 1'b0;
	else if (grant && cpu_rnw)
		rd_pend <= 1'b1;
	else if (c2)
		rd_pend <= 1'b0;

	assign cpu_strobe = rd_pend & c2; // 3 fclk after grant

endmodule

/* rtl/zclk_phase.sv */
`timescale 1ns/1ps

module zclk_phase (
	input  logic             fclk,
	input  logic             rst_n,
	input  zmem_pkg::turbo_t turbo,
	input  logic             cpu_stall,
	output logic             c0,
	output logic             c1,
	output logic             c2,
	output logic             c3,
	output logic             zclk,
	output logic             zpos,
	output logic             zneg
);

	logic [2:0] cnt;     // low two bits are the dram slot phase
	logic [2:0] cnt_nxt;
	logic       pos_pt;  // rising edge point for the coming cycle
	logic       neg_pt;  // falling edge point for the coming cycle
	logic       zclk_nxt;

	assign cnt_nxt = cnt + 3'd1;

	// edge points locked to the counter so zclk always lines up with c0..c3
	always_comb
	begin
		case (turbo)
			zmem_pkg::TURBO_3M5:
			begin
				pos_pt = (cnt_nxt == 3'd4);
				neg_pt = (cnt_nxt == 3'd0);
			end
			zmem_pkg::TURBO_7M:
			begin
				pos_pt = (cnt_nxt[1:0] == 2'd2);
				neg_pt = (cnt_nxt[1:0] == 2'd0);
			end
			default: // 14 MHz, one fclk per half period
			begin
				pos_pt = cnt_nxt[0];
				neg_pt = ~cnt_nxt[0];
			end
		endcase
	end

	assign zclk_nxt = zpos ? 1'b1 : (zneg ? 1'b0 : zclk); // level seen next cycle

	always_ff @(posedge fclk or negedge rst_n)
	if (!rst_n)
	begin
		cnt  <= 3'd0;
		zclk <= 1'b1; // first edge is a fall
		zpos <= 1'b0;
		zneg <= 1'b0;
	end
	else
	begin
		cnt  <= cnt_nxt;
		zclk <= zclk_nxt;
		zpos <= pos_pt & ~zclk_nxt;
		zneg <= neg_pt & zclk_nxt & ~cpu_stall; // stall keeps zclk high
	end

	assign c0 = (cnt[1:0] == 2'd0);
	assign c1 = (cnt[1:0] == 2'd1);
	assign c2 = (cnt[1:0] == 2'd2);
	assign c3 = (cnt[1:0] == 2'd3);

endmodule

/* rtl/zmem_ctrl.sv */
`timescale 1ns/1ps

module zmem_ctrl (
	input  logic             fclk,
	input  logic             rst_n,
	input  zmem_pkg::turbo_t turbo,
	input  logic             c1,
	input  logic             c2,
	input  logic             c3,
	input  logic             zneg,
	input  logic             m1_n,
	input  logic             mreq_n,
	input  logic             rd_n,
	input  logic             wr_n,
	input  logic             rfsh_n,
	input  logic             romnram,
	input  logic             cache_hit,
	input  logic             cpu_next,
	output logic             cpu_req,
	output logic             cpu_rnw,
	output logic             cpu_stall
);

	zmem_pkg::stall_state_t state;
	zmem_pkg::stall_state_t state_nxt;

	logic turbo14;
	logic r_mreq_n;               // mreq on previous zneg
	logic opfetch, memrd, memwr;
	logic dram_beg;               // zneg that opens a dram access
	logic grant;
	logic rnw_r;                  // direction of the held request
	logic stall14;
	logic ramreq, ramrd, ramwr;   // 3.5/7 MHz conditions
	logic ramrd_reg, ramwr_reg;
	logic cpureq_357;

	assign turbo14 = (turbo >= zmem_pkg::TURBO_14M);

	assign opfetch = ~mreq_n & ~m1_n;
	assign memrd   = ~mreq_n & ~rd_n;
	assign memwr   = ~mreq_n & rd_n & rfsh_n; // write known before wr_n falls

	always_ff @(posedge fclk or negedge rst_n)
	if (!rst_n)
		r_mreq_n <= 1'b1;
	else if (zneg)
		r_mreq_n <= mreq_n | ~rfsh_n;

	// ram access not served by the word buffer
	assign dram_beg = turbo14 & zneg & r_mreq_n & ~mreq_n & rfsh_n & ~romnram &
		(~cache_hit | memwr);

	assign grant = cpu_req & cpu_next & c3; // arbiter takes it on the same terms

	always_comb
	begin
		state_nxt = state;
		case (state)
			zmem_pkg::st_idle:
				if (dram_beg)
				begin
					if (!grant)
						state_nxt = zmem_pkg::st_wait_slot;
					else if (!memwr)
						state_nxt = zmem_pkg::st_wait_data;
				end
			zmem_pkg::st_wait_slot:
				if (grant)
					state_nxt = rnw_r ? zmem_pkg::st_wait_data : zmem_pkg::st_idle;
			zmem_pkg::st_wait_data:
				if (c2) // strobe cycle, word lands in the buffer
					state_nxt = zmem_pkg::st_finish;
			default: // st_finish
				if (opfetch ? c2 : c1)
					state_nxt = zmem_pkg::st_idle;
		endcase
	end

	always_ff @(posedge fclk or negedge rst_n)
	if (!rst_n)
		state <= zmem_pkg::st_idle;
	else
		state <= state_nxt;

	always_ff @(posedge fclk)
	if (dram_beg)
		rnw_r <= ~memwr;

	// writes only wait for a free slot, reads wait for the data
	assign stall14 = (dram_beg & (~cpu_next | opfetch | memrd)) |
		((state == zmem_pkg::st_wait_slot) & (rnw_r | ~cpu_next)) |
		(state == zmem_pkg::st_wait_data) |
		(state == zmem_pkg::st_finish);

	// 3.5/7 MHz: one request per rising read or write condition
	assign ramreq = ~mreq_n & ~romnram & rfsh_n;
	assign ramrd  = ramreq & ~rd_n;
	assign ramwr  = ramreq & ~wr_n;

	always_ff @(posedge fclk or negedge rst_n)
	if (!rst_n)
	begin
		ramrd_reg <= 1'b0;
		ramwr_reg <= 1'b0;
	end
	else if (c3 && !cpu_stall) // held while the slot is refused
	begin
		ramrd_reg <= ramrd;
		ramwr_reg <= ramwr;
	end

	assign cpureq_357 = (ramrd & ~ramrd_reg) | (ramwr & ~ramwr_reg);

	assign cpu_req   = turbo14 ? ((state == zmem_pkg::st_wait_slot) | dram_beg) : cpureq_357;
	assign cpu_rnw   = turbo14 ? (dram_beg ? ~memwr : rnw_r) : ramrd;
	assign cpu_stall = turbo14 ? stall14 : (cpureq_357 & ~cpu_next);

endmodule

/* rtl/zmem_pager.sv */
`timescale 1ns/1ps

module zmem_pager (
	input  zmem_pkg::zaddr_t za,
	input  logic             win0_romnram, // 1 - rom in window, 0 - ram
	input  logic             win1_romnram,
	input  logic             win2_romnram,
	input  logic             win3_romnram,
	input  zmem_pkg::page_t  win0_page,
	input  zmem_pkg::page_t  win1_page,
	input  zmem_pkg::page_t  win2_page,
	input  zmem_pkg::page_t  win3_page,
	input  logic             romrw_en,     // flash write enable
	input  logic             mreq_n,
	input  logic             rd_n,
	input  logic             wr_n,
	output logic             romnram,
	output zmem_pkg::rompg_t rompg,
	output logic             romoe_n,
	output logic             romwe_n,
	output logic             csrom,
	output zmem_pkg::daddr_t cpu_addr
);

	zmem_pkg::page_t page; // page of the selected window

	// window by top two address bits
	always_comb
	begin
		case (za[15:14])
			2'b00:   begin page = win0_page; romnram = win0_romnram; end
			2'b01:   begin page = win1_page; romnram = win1_romnram; end
			2'b10:   begin page = win2_page; romnram = win2_romnram; end
			default: begin page = win3_page; romnram = win3_romnram; end
		endcase
	end

	assign rompg = page[zmem_pkg::ROM_PAGE_BITS-1:0]; // upper page bits ignored for rom

	// chip select picks rom vs ram, strobes follow the bus
	assign romoe_n = rd_n | mreq_n;
	assign romwe_n = wr_n | mreq_n | ~romrw_en;
	assign csrom   = romnram; // active high

	assign cpu_addr = {page, za[13:1]}; // word address, byte lane is za[0]

endmodule

/* rtl/zmem_pkg.sv */
package zmem_pkg;

	// z80 side
	typedef logic [15:0] zaddr_t;
	typedef logic [7:0]  zdata_t;

	// paging
	typedef logic [7:0]  page_t;  // 16k page in a window
	typedef logic [4:0]  rompg_t; // rom page, half a megabyte reach

	// dram side
	typedef logic [15:0] dword_t; // one dram word, two z80 bytes
	typedef logic [20:0] daddr_t; // {page, za[13:1]}

	// number of page bits that reach the rom chip
	localparam int ROM_PAGE_BITS = 5;

	// turbo select
	typedef logic [1:0] turbo_t;

	localparam turbo_t TURBO_3M5 = 2'b00;
	localparam turbo_t TURBO_7M  = 2'b01;
	localparam turbo_t TURBO_14M = 2'b10; // 2'b11 runs at 14 MHz too

	// 14 MHz stall controller
	typedef enum logic [1:0]
	{
		st_idle,      // no dram access in flight
		st_wait_slot, // request held until c3 with cpu_next
		st_wait_data, // granted, word arrives on next c2
		st_finish     // data in buffer, release on c2 or c1
	} stall_state_t;

endpackage

/* rtl/zmem_top.sv */
`timescale 1ns/1ps

module zmem_top #(
	parameter int VIDEO_PERIOD    = 4,
	parameter int DRAM_WORDS_LOG2 = 12
) (
	input  logic             fclk,
	input  logic             rst_n,
	input  zmem_pkg::zaddr_t za,
	input  zmem_pkg::zdata_t zd_in,
	input  logic             m1_n,
	input  logic             mreq_n,
	input  logic             iorq_n,
	input  logic             rd_n,
	input  logic             wr_n,
	input  logic             rfsh_n,
	input  zmem_pkg::turbo_t int_turbo,
	input  logic             win0_romnram,
	input  logic             win1_romnram,
	input  logic             win2_romnram,
	input  logic             win3_romnram,
	input  zmem_pkg::page_t  win0_page,
	input  zmem_pkg::page_t  win1_page,
	input  zmem_pkg::page_t  win2_page,
	input  zmem_pkg::page_t  win3_page,
	input  logic             romrw_en,
	output logic             zclk,
	output logic             zpos,
	output logic             zneg,
	output zmem_pkg::zdata_t zd_out,
	output logic             zd_ena,
	output zmem_pkg::rompg_t rompg,
	output logic             romoe_n,
	output logic             romwe_n,
	output logic             csrom,
	output logic             cpu_stall
);

	logic             c1, c2, c3; // slot phases, c0 has no user here
	logic             romnram;
	logic             cache_hit;
	logic             cpu_req, cpu_rnw, cpu_next, cpu_strobe;
	zmem_pkg::daddr_t cpu_addr;
	zmem_pkg::dword_t cpu_rddata;

	zclk_phase u_phase (
		.fclk(fclk), .rst_n(rst_n), .turbo(int_turbo), .cpu_stall(cpu_stall),
		.c0(), .c1(c1), .c2(c2), .c3(c3), .zclk(zclk), .zpos(zpos), .zneg(zneg)
	);

	zmem_pager u_pager (
		.za(za), .win0_romnram(win0_romnram), .win1_romnram(win1_romnram),
		.win2_romnram(win2_romnram), .win3_romnram(win3_romnram),
		.win0_page(win0_page), .win1_page(win1_page),
		.win2_page(win2_page), .win3_page(win3_page),
		.romrw_en(romrw_en), .mreq_n(mreq_n), .rd_n(rd_n), .wr_n(wr_n),
		.romnram(romnram), .rompg(rompg), .romoe_n(romoe_n), .romwe_n(romwe_n),
		.csrom(csrom), .cpu_addr(cpu_addr)
	);

	zmem_word_cache u_cache (
		.fclk(fclk), .rst_n(rst_n), .za(za), .mreq_n(mreq_n), .rd_n(rd_n),
		.rfsh_n(rfsh_n), .iorq_n(iorq_n), .zpos(zpos), .zneg(zneg), .romnram(romnram),
		.cpu_strobe(cpu_strobe), .cpu_rddata(cpu_rddata),
		.zd_out(zd_out), .zd_ena(zd_ena), .cache_hit(cache_hit)
	);

	zmem_ctrl u_ctrl (
		.fclk(fclk), .rst_n(rst_n), .turbo(int_turbo), .c1(c1), .c2(c2), .c3(c3),
		.zneg(zneg), .m1_n(m1_n), .mreq_n(mreq_n), .rd_n(rd_n), .wr_n(wr_n),
		.rfsh_n(rfsh_n), .romnram(romnram), .cache_hit(cache_hit), .cpu_next(cpu_next),
		.cpu_req(cpu_req), .cpu_rnw(cpu_rnw), .cpu_stall(cpu_stall)
	);

	// write byte straight from the z80 bus, lane by za[0]
	dram_slot_arb #(
		.VIDEO_PERIOD(VIDEO_PERIOD),
		.DRAM_WORDS_LOG2(DRAM_WORDS_LOG2)
	) u_arb (
		.fclk(fclk), .rst_n(rst_n), .c2(c2), .c3(c3), .cpu_req(cpu_req),
		.cpu_rnw(cpu_rnw), .cpu_addr(cpu_addr), .cpu_wrdata(zd_in), .cpu_wrbsel(za[0]),
		.cpu_next(cpu_next), .cpu_strobe(cpu_strobe), .cpu_rddata(cpu_rddata)
	);

endmodule

/* rtl/zmem_word_cache.sv */
`timescale 1ns/1ps

module zmem_word_cache (
	input  logic             fclk,
	input  logic             rst_n,
	input  zmem_pkg::zaddr_t za,
	input  logic             mreq_n,
	input  logic             rd_n,
	input  logic             rfsh_n,
	input  logic             iorq_n,
	input  logic             zpos,
	input  logic             zneg,
	input  logic             romnram,
	input  logic             cpu_strobe,
	input  zmem_pkg::dword_t cpu_rddata,
	output zmem_pkg::zdata_t zd_out,
	output logic             zd_ena,
	output logic             cache_hit
);

	zmem_pkg::dword_t rd_buf;      // last word fetched from dram
	logic [15:1]      cached_addr;
	logic             valid;
	logic             r_mreq_n;    // mreq as seen on previous zneg
	logic             io_r;
	logic             mem_start;   // first zneg of a memory cycle
	logic             memwr;
	logic             io_start;

	assign memwr     = ~mreq_n & rd_n & rfsh_n; // rd_n still high at T1 zneg
	assign mem_start = zneg & r_mreq_n & ~mreq_n & rfsh_n;
	assign io_start  = zpos & ~iorq_n & ~io_r;

	always_ff @(posedge fclk or negedge rst_n)
	if (!rst_n)
	begin
		r_mreq_n <= 1'b1;
		io_r     <= 1'b0;
	end
	else
	begin
		if (zneg)
			r_mreq_n <= mreq_n | ~rfsh_n; // refresh does not count as access
		if (zpos)
			io_r <= ~iorq_n;
	end

	// rom access, any write or new io cycle drops the buffered word
	always_ff @(posedge fclk or negedge rst_n)
	if (!rst_n)
		valid <= 1'b0;
	else if ((mem_start & (romnram | memwr)) | io_start)
		valid <= 1'b0;
	else if (cpu_strobe)
		valid <= 1'b1;

	always_ff @(posedge fclk)
	if (cpu_strobe)
	begin
		rd_buf      <= cpu_rddata;
		cached_addr <= za[15:1];
	end

	assign cache_hit = valid & (za[15:1] == cached_addr);

	assign zd_out = za[0] ? rd_buf[15:8] : rd_buf[7:0]; // byte lane
	assign zd_ena = ~mreq_n & ~rd_n & ~romnram;         // ram read drives the bus

endmodule

/* tests/tb_zmem_model.svh */
`ifndef TB_ZMEM_MODEL_SVH
`define TB_ZMEM_MODEL_SVH

// byte image of dram, folded the way the arbiter's word array folds
logic [7:0]  ram_model [MODEL_BYTES];
bit          ram_known [MODEL_BYTES]; // only written bytes are compared
bit          cache_valid;             // expected state of the word buffer
logic [15:1] cache_tag;
bit          saw_stall;               // cpu_stall seen during current cycle

// window page plus za[13:1], upper word bits wrap, za[0] picks the byte
function automatic int ram_index(input zmem_pkg::zaddr_t a);
	logic [20:0] word;
	word = {win_pg[a[15:14]], a[13:1]};
	return int'({word[DRAM_WORDS_LOG2-1:0], a[0]});
endfunction

task automatic report_error(input string msg);
	$display("ERROR at %0t ns: %s", $time, msg);
	errors++;
endtask

// both waits land on the falling fclk edge inside the strobe cycle
task automatic wait_zpos();
	do
	begin
		@(negedge fclk);
		if (cpu_stall)
			saw_stall = 1'b1;
	end
	while (!zpos);
endtask

task automatic wait_zneg();
	do
	begin
		@(negedge fclk);
		if (cpu_stall)
			saw_stall = 1'b1;
	end
	while (!zneg);
endtask

task automatic mem_read(input zmem_pkg::zaddr_t a);
	int               idx;
	bit               rom;
	bit               hit;
	time              t0;
	zmem_pkg::zdata_t d;
	logic             ena;
	logic             oe_n;
	logic             cs;
	zmem_pkg::rompg_t pg;
	idx = ram_index(a);
	rom = win_rom[a[15:14]];
	hit = cache_valid && (cache_tag == a[15:1]) && !rom;
	wait_zpos(); // T1
	t0 = $time;
	za = a;
	saw_stall = 1'b0;
	if (romoe_n !== 1'b1)
		report_error("romoe_n low before the read started");
	wait_zneg();
	mreq_n = 1'b0;
	rd_n   = 1'b0;
	wait_zpos();
	wait_zneg(); // T2, frozen while stalled
	wait_zpos();
	wait_zneg(); // T3, data taken here
	d    = zd_out;
	ena  = zd_ena;
	oe_n = romoe_n;
	cs   = csrom;
	pg   = rompg;
	mreq_n = 1'b1;
	rd_n   = 1'b1;
	bus_cycles++;
	if (oe_n !== 1'b0)
		report_error($sformatf("romoe_n not low during read of %h", a));
	if (cs !== rom)
		report_error($sformatf("csrom %b for %h, expected %b", cs, a, rom));
	if (pg !== win_pg[a[15:14]][4:0])
		report_error($sformatf("rompg %h for %h, expected %h", pg, a, win_pg[a[15:14]][4:0]));
	if (ena !== !rom)
		report_error($sformatf("zd_ena %b during read of %h", ena, a));
	if (!rom && ram_known[idx] && d !== ram_model[idx])
		report_error($sformatf("read %h gave %h, expected %h", a, d, ram_model[idx]));
	if (!rom && int_turbo[1] && saw_stall == hit)
		report_error($sformatf("read %h: stall %b with predicted hit %b", a, saw_stall, hit));
	if ($time - t0 > MAX_BUS_FCLK * CLK_PERIOD)
		report_error($sformatf("read %h took %0t ns", a, $time - t0));
	if (rom)
		cache_valid = 1'b0; // rom access drops the buffer
	else
	begin
		cache_valid = 1'b1;
		cache_tag   = a[15:1];
	end
endtask

task automatic mem_write(input zmem_pkg::zaddr_t a, input zmem_pkg::zdata_t d);
	int   idx;
	bit   rom;
	time  t0;
	logic we_n;
	logic cs;
	idx = ram_index(a);
	rom = win_rom[a[15:14]];
	wait_zpos();
	t0    = $time;
	za    = a;
	zd_in = d; // z80 puts data out early in T1
	wait_zneg();
	mreq_n = 1'b0;
	wait_zpos();
	wait_zneg();
	wr_n = 1'b0;
	wait_zpos(); // T3 high half, wr_n still low
	we_n = romwe_n;
	cs   = csrom;
	wait_zneg();
	mreq_n = 1'b1;
	wr_n   = 1'b1;
	bus_cycles++;
	if (cs !== rom)
		report_error($sformatf("csrom %b on write to %h", cs, a));
	// we strobe follows the bus, csrom keeps it off the chip for ram
	if (we_n !== !romrw_en)
		report_error($sformatf("romwe_n %b on write to %h, romrw_en %b", we_n, a, romrw_en));
	if ($time - t0 > MAX_BUS_FCLK * CLK_PERIOD)
		report_error($sformatf("write %h took %0t ns", a, $time - t0));
	if (!rom)
	begin
		ram_model[idx] = d;
		ram_known[idx] = 1'b1;
	end
	cache_valid = 1'b0; // any memory write
endtask

task automatic io_cycle();
	wait_zpos();
	za = 16'($urandom);
	wait_zpos(); // iorq goes low in T2
	iorq_n = 1'b0;
	rd_n   = 1'b0;
	wait_zneg();
	wait_zpos();
	wait_zneg();
	iorq_n = 1'b1;
	rd_n   = 1'b1;
	bus_cycles++;
	cache_valid = 1'b0;
endtask

`endif

/* tests/tb_zmem.sv */
`timescale 1ns/1ps

module tb_zmem;

	localparam int CLK_PERIOD      = 10;
	localparam int VIDEO_PERIOD    = 4;
	localparam int DRAM_WORDS_LOG2 = 12;
	localparam int MODEL_BYTES     = 2 ** (DRAM_WORDS_LOG2 + 1);
	localparam int MAX_BUS_FCLK    = 48;   // 3.5 MHz cycle plus a refused slot, with slack
	localparam int N_RW            = 40;
	localparam int N_ROM           = 30;
	localparam int N_CACHE         = 20;
	localparam int N_MIX_CHUNKS    = 10;
	localparam int N_MIX_LEN       = 20;   // bus cycles per mixed chunk
	// every bus cycle the tests issue, page switches included
	localparam int BUS_CYCLES      = 3 * (1 + 3 * N_RW) + (1 + 4 * N_ROM) +
		(1 + 6 * N_CACHE) + N_MIX_CHUNKS * (1 + N_MIX_LEN);
	localparam int SEED            = 32'hd2468165;

	logic             fclk;
	logic             rst_n;
	zmem_pkg::zaddr_t za;
	zmem_pkg::zdata_t zd_in;
	logic             m1_n, mreq_n, iorq_n, rd_n, wr_n, rfsh_n;
	zmem_pkg::turbo_t int_turbo;
	logic             win_rom [4];
	zmem_pkg::page_t  win_pg [4];
	logic             romrw_en;
	logic             zclk, zpos, zneg;
	zmem_pkg::zdata_t zd_out;
	logic             zd_ena;
	zmem_pkg::rompg_t rompg;
	logic             romoe_n, romwe_n, csrom, cpu_stall;

	int errors;
	int tests;
	int bus_cycles;

	`include "tb_zmem_model.svh"

	zmem_top #(
		.VIDEO_PERIOD(VIDEO_PERIOD),
		.DRAM_WORDS_LOG2(DRAM_WORDS_LOG2)
	) uut (
		.fclk(fclk), .rst_n(rst_n), .za(za), .zd_in(zd_in), .m1_n(m1_n), .mreq_n(mreq_n),
		.iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n), .rfsh_n(rfsh_n), .int_turbo(int_turbo),
		.win0_romnram(win_rom[0]), .win1_romnram(win_rom[1]),
		.win2_romnram(win_rom[2]), .win3_romnram(win_rom[3]),
		.win0_page(win_pg[0]), .win1_page(win_pg[1]),
		.win2_page(win_pg[2]), .win3_page(win_pg[3]), .romrw_en(romrw_en),
		.zclk(zclk), .zpos(zpos), .zneg(zneg), .zd_out(zd_out), .zd_ena(zd_ena),
		.rompg(rompg), .romoe_n(romoe_n), .romwe_n(romwe_n), .csrom(csrom),
		.cpu_stall(cpu_stall)
	);

	initial
	begin
		fclk = 1'b0;
		forever #(CLK_PERIOD / 2) fclk = ~fclk;
	end

	initial
	begin
		#(BUS_CYCLES * MAX_BUS_FCLK * 2 * CLK_PERIOD);
		$display("timeout: the watchdog stopped the run before all tests finished");
		$display(">>> FAIL");
		$finish;
	end

	// switch clock rate with the bus idle, then let the slot registers settle
	task automatic set_turbo(input zmem_pkg::turbo_t t);
		@(negedge fclk);
		int_turbo = t;
		repeat (8) @(negedge fclk);
	endtask

	// page registers sit behind i/o ports
	task automatic set_windows(input logic [3:0] rom_mask);
		io_cycle();
		for (int w = 0; w < 4; w++)
		begin
			win_rom[w] = rom_mask[w];
			win_pg[w]  = 8'($urandom);
		end
	endtask

	task automatic end_test(input string name, input int err_before);
		tests++;
		$display("test %s done, %0d errors", name, errors - err_before);
	endtask

	initial
	begin
		int               e0;
		int               gap;
		int               hi;
		int               exp_gap;
		zmem_pkg::zaddr_t a;
		zmem_pkg::zaddr_t a2;
		zmem_pkg::zaddr_t last_wr;
		zmem_pkg::zdata_t d;
		void'($urandom(SEED));
		errors     = 0;
		tests      = 0;
		bus_cycles = 0;
		rst_n      = 1'b0;
		za         = '0;
		zd_in      = '0;
		m1_n       = 1'b1; // no opcode fetches, plain reads only
		mreq_n     = 1'b1;
		iorq_n     = 1'b1;
		rd_n       = 1'b1;
		wr_n       = 1'b1;
		rfsh_n     = 1'b1;
		int_turbo  = 2'b10;
		romrw_en   = 1'b0;
		last_wr    = '0;
		for (int w = 0; w < 4; w++)
		begin
			win_rom[w] = 1'b0;
			win_pg[w]  = '0;
		end
		repeat (3) @(negedge fclk);
		rst_n = 1'b1;

		// idle outputs right after reset
		e0 = errors;
		@(negedge fclk);
		if (zd_ena !== 1'b0 || cpu_stall !== 1'b0 || romwe_n !== 1'b1)
			report_error("outputs not idle after reset");
		end_test("reset", e0);

		// write then read back, also through an aliased window
		e0 = errors;
		for (int t = 0; t < 3; t++)
		begin
			set_turbo(2'(t));
			set_windows(4'b0000);
			win_pg[2] = win_pg[1]; // windows 1 and 2 share a page
			for (int i = 0; i < N_RW; i++)
			begin
				a = 16'($urandom);
				d = 8'($urandom);
				mem_write(a, d);
				mem_read(a);
				a2 = (a[15:14] == 2'b01 || a[15:14] == 2'b10) ? a ^ 16'hc000 : a;
				mem_read(a2);
			end
		end
		end_test("ram write/read", e0);

		// rom in window 0, window 3 is ram on the same page
		e0 = errors;
		set_turbo(2'($urandom));
		set_windows(4'b0001);
		win_pg[3] = win_pg[0];
		for (int i = 0; i < N_ROM; i++)
		begin
			a        = {2'b00, 14'($urandom)};
			d        = 8'($urandom);
			romrw_en = 1'($urandom);
			mem_write(a | 16'hc000, d);
			mem_write(a, ~d); // must not reach dram
			mem_read(a);
			mem_read(a | 16'hc000);
		end
		romrw_en = 1'b0;
		end_test("rom mapping", e0);

		// word buffer at 14 MHz, window 3 is rom
		e0 = errors;
		set_turbo(2'b10);
		set_windows(4'b1000);
		for (int i = 0; i < N_CACHE; i++)
		begin
			a = {1'b0, 15'($urandom)};
			mem_write({a[15:1], 1'b0}, 8'($urandom));
			mem_write({a[15:1], 1'b1}, 8'($urandom));
			mem_read(a);               // miss
			mem_read(a ^ 16'h0001);    // other byte, expected hit
			case ($urandom % 3)
				0:       mem_write(a ^ 16'h0100, 8'($urandom));
				1:       mem_read({2'b11, 14'($urandom)});
				default: io_cycle();
			endcase
			mem_read(a ^ 16'h0001);    // stalls again
		end
		end_test("word cache", e0);

		// zpos spacing and zclk half period per turbo mode, bus idle
		e0 = errors;
		for (int t = 0; t < 4; t++)
		begin
			set_turbo(2'(t));
			wait_zpos();
			wait_zpos();
			exp_gap = (t >= 2) ? 2 : ((t == 0) ? 8 : 4);
			for (int k = 0; k < 4; k++)
			begin
				gap = 0;
				hi  = 0;
				do
				begin
					@(negedge fclk);
					gap++;
					if (zclk === 1'b1)
						hi++; // high half of the bus clock
				end
				while (!zpos);
				if (gap != exp_gap)
					report_error($sformatf("turbo %0d: zpos gap %0d, expected %0d",
						t, gap, exp_gap));
				if (hi != exp_gap / 2)
					report_error($sformatf("turbo %0d: zclk high %0d of %0d cycles",
						t, hi, gap));
			end
		end
		end_test("zclk rate", e0);

		// mixed traffic against video slots
		e0 = errors;
		for (int c = 0; c < N_MIX_CHUNKS; c++)
		begin
			set_turbo(2'($urandom));
			set_windows(4'($urandom) & 4'b0011); // windows 2 and 3 stay ram
			romrw_en = 1'($urandom);
			for (int i = 0; i < N_MIX_LEN; i++)
			begin
				a = 16'($urandom);
				d = 8'($urandom);
				case ($urandom % 10)
					0, 1, 2, 3:
					begin
						mem_write(a, d);
						last_wr = a;
					end
					4, 5:    mem_read(last_wr);
					6, 7:    mem_read(a);
					8:       mem_read(last_wr ^ 16'h0001); // neighbour byte, often buffered
					default: io_cycle();
				endcase
			end
		end
		romrw_en = 1'b0;
		end_test("mixed traffic", e0);

		$display("summary: %0d tests, %0d bus cycles, %0d errors", tests, bus_cycles, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule
